//--- project.f
+incdir+include
rtl/pkt_bus_pkg.sv
rtl/pkt_buf_pkg.sv
rtl/packet_enqueue.sv
rtl/packet_buffer_mem.sv
rtl/packet_enqueue_top.sv
tests/packet_enqueue_asserts.sv
tests/packet_enqueue_tb.sv

//--- Makefile
# Verilator flow for the packet enqueue subsystem
VERILATOR  ?= verilator
TOP        ?= packet_enqueue_tb
RTL_TOP    ?= packet_enqueue_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/packet_enqueue_cases.txt
# name len_bytes meta_hex err head_ptr_hex outcome start_addr_hex
# outcome is keep or a drop reason: err, short, long, ovfl
good_basic   20 a101 0 00 keep  00
err_flag     16 a102 1 05 err   05
min_minus1    7 a103 0 05 short 05
min_exact     8 a104 0 05 keep  05
max_exact    64 a105 0 07 keep  07
max_plus1    65 a106 0 17 long  17
ovfl_big     20 a107 0 5a ovfl  17
ovfl_fit     12 a108 0 5a keep  17
wrap_a       60 b201 0 1a keep  1a
wrap_b       62 b202 0 29 keep  29
wrap_c       40 b203 0 39 keep  39
wrap_d       33 b204 0 43 keep  03
wrap_e       50 b205 0 4c keep  0c
wrap_err     24 b206 1 59 err   19
wrap_f       44 b207 0 59 keep  19
wrap_g       64 b208 0 64 keep  24
wrap_h       56 b209 0 74 keep  34
after_wrap   12 b20a 0 02 keep  02
ovfl_wrap    12 b20b 0 47 ovfl  05
fit_wrap      8 b20c 0 47 keep  05

//--- tests/packet_enqueue_tb.sv
`timescale 1ns/1ps
`include "pkt_macros.svh"

module packet_enqueue_tb;
    import pkt_bus_pkg::*;
    import pkt_buf_pkg::*;

    localparam int CYCLES_PER_CASE = 200;
    localparam int EVENT_WAIT      = 8;

    logic         clk;
    logic         rst;
    logic         in_valid;
    pkt_word_t    in_word;
    buf_ptr_t     head_ptr;
    buf_addr_t    rd_addr;
    pkt_data_t    rd_data;
    logic         desc_valid;
    pkt_desc_t    desc;
    logic         drop_valid;
    drop_reason_t drop_reason;
    buf_ptr_t     tail_ptr;

    // Case table with one entry per line of the case file
    string        case_name[$];
    string        case_outcome[$];
    int           case_len[$];
    pkt_meta_t    case_meta[$];
    logic         case_err[$];
    buf_ptr_t     case_head[$];
    buf_addr_t    case_addr[$];

    pkt_data_t    sent_words[$];
    logic [31:0]  lcg_state    = 32'h26cd;
    logic         cases_loaded = 1'b0;
    buf_ptr_t     model_tail;

    packet_enqueue_top dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .head_ptr    (head_ptr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .desc_valid  (desc_valid),
        .desc        (desc),
        .drop_valid  (drop_valid),
        .drop_reason (drop_reason),
        .tail_ptr    (tail_ptr)
    );

    bind packet_enqueue packet_enqueue_asserts u_asserts (
        .clk        (clk),
        .rst        (rst),
        .desc_valid (desc_valid),
        .drop_valid (drop_valid),
        .wr_en      (wr_en),
        .state      (state),
        .tail_ptr   (tail_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic drop_reason_t reason_from_text(input string s);
        if (s == "err") return DROP_ERR;
        if (s == "short") return DROP_SHORT;
        if (s == "long") return DROP_LONG;
        return DROP_OVFL;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERR %s %s: expected 0x%0h actual 0x%0h",
                               name, what, expected, actual));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        int          len;
        int          err;
        string       line;
        string       name;
        string       outcome;
        logic [15:0] meta;
        logic [7:0]  head;
        logic [7:0]  addr;
        fd = $fopen("tests/packet_enqueue_cases.txt", "r");
        if (fd == 0) fail_run("Could not open the case file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            code = $sscanf(line, "%s %d %h %d %h %s %h",
                           name, len, meta, err, head, outcome, addr);
            if (code != 7 || len < 1) fail_run($sformatf("Malformed case line: %s", line));
            if (!(outcome == "keep" || outcome == "err" || outcome == "short" ||
                  outcome == "long" || outcome == "ovfl")) begin
                fail_run($sformatf("Unknown outcome in case %s", name));
            end
            case_name.push_back(name);
            case_outcome.push_back(outcome);
            case_len.push_back(len);
            case_meta.push_back(meta);
            case_err.push_back(err != 0);
            case_head.push_back(buf_ptr_t'(head));
            case_addr.push_back(buf_addr_t'(addr));
        end
        $fclose(fd);
        if (case_name.size() == 0) fail_run("The case file holds no cases");
    endtask

    // Words go out back to back and the last one carries eop, mty, err and meta
    task automatic send_packet(input int len, input pkt_meta_t meta, input logic err);
        int        n_words;
        pkt_word_t w;
        n_words = (len + `PKT_WORD_BYTES - 1) / `PKT_WORD_BYTES;
        sent_words.delete();
        for (int i = 0; i < n_words; i++) begin
            lcg_state = next_random(lcg_state);
            sent_words.push_back(lcg_state);
            w      = '0;
            w.data = lcg_state;
            if (i == n_words - 1) begin
                w.eop  = 1'b1;
                w.mty  = pkt_mty_t'(len % `PKT_WORD_BYTES);
                w.err  = err;
                w.meta = meta;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_word  = w;
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_word  = '0;
    endtask

    task automatic wait_for_event(input string name);
        int waited;
        waited = 0;
        while (!(desc_valid || drop_valid)) begin
            if (waited == EVENT_WAIT) begin
                fail_run($sformatf("Case %s: no descriptor or drop event after eop", name));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Read data is there one negedge after the address
    task automatic read_back(input string name, input buf_addr_t start);
        for (int i = 0; i < sent_words.size(); i++) begin
            rd_addr = start + buf_addr_t'(i);
            @(negedge clk);
            compare_value(name, $sformatf("word %0d", i), sent_words[i], rd_data);
        end
    endtask

    task automatic run_case(input int idx);
        string name;
        logic  keep;
        int    n_words;
        name    = case_name[idx];
        keep    = (case_outcome[idx] == "keep");
        n_words = (case_len[idx] + `PKT_WORD_BYTES - 1) / `PKT_WORD_BYTES;
        @(negedge clk);
        head_ptr = case_head[idx];
        compare_value(name, "tail before", 32'(model_tail), 32'(tail_ptr));
        send_packet(case_len[idx], case_meta[idx], case_err[idx]);
        wait_for_event(name);
        // Event kind as {desc_valid, drop_valid}
        compare_value(name, "event", keep ? 32'd2 : 32'd1, 32'({desc_valid, drop_valid}));
        if (keep) begin
            compare_value(name, "addr", 32'(case_addr[idx]), 32'(desc.addr));
            compare_value(name, "addr vs tail", 32'(buf_addr_t'(model_tail)), 32'(desc.addr));
            compare_value(name, "len", 32'(case_len[idx]), 32'(desc.len));
            compare_value(name, "meta", 32'(case_meta[idx]), 32'(desc.meta));
            model_tail = model_tail + buf_ptr_t'(n_words);
        end else begin
            compare_value(name, "drop_reason", 32'(reason_from_text(case_outcome[idx])),
                          32'(drop_reason));
        end
        compare_value(name, "tail after", 32'(model_tail), 32'(tail_ptr));
        @(negedge clk);
        compare_value(name, "pulse width", 32'd0, 32'({desc_valid, drop_valid}));
        if (keep) read_back(name, case_addr[idx]);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_word    = '0;
        head_ptr   = '0;
        rd_addr    = '0;
        model_tail = '0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_value("reset", "desc_valid", 32'd0, 32'(desc_valid));
        compare_value("reset", "drop_valid", 32'd0, 32'(drop_valid));
        compare_value("reset", "tail_ptr", 32'd0, 32'(tail_ptr));
        for (int i = 0; i < case_name.size(); i++) begin
            run_case(i);
        end
        $display("Ran %0d cases", case_name.size());
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (cases_loaded);
        repeat ((case_name.size() + 1) * CYCLES_PER_CASE) @(posedge clk);
        fail_run("Timeout: the cases did not finish in the allowed number of cycles");
    end

endmodule

//--- tests/packet_enqueue_asserts.sv
`timescale 1ns/1ps

module packet_enqueue_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  desc_valid,
    input logic                  drop_valid,
    input logic                  wr_en,
    input logic [1:0]            state,
    input pkt_buf_pkg::buf_ptr_t tail_ptr
);
    // Encoding of ST_DISCARD in the enqueue FSM
    localparam logic [1:0] ST_DISCARD_CODE = 2'd2;

    // ======================================================================
    // Packet outcome and tail pointer rules
    // ======================================================================

    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        !(desc_valid && drop_valid))
        else $error("desc_valid and drop_valid high in the same cycle");

    a_no_write_in_discard: assert property (@(posedge clk) disable iff (rst)
        (state == ST_DISCARD_CODE) |-> !wr_en)
        else $error("wr_en high while the FSM discards a packet");

    // Tail only moves on a commit
    a_tail_on_desc: assert property (@(posedge clk) disable iff (rst)
        (tail_ptr != $past(tail_ptr)) |-> desc_valid)
        else $error("tail_ptr moved without desc_valid");

endmodule

//--- rtl/packet_enqueue_top.sv
`timescale 1ns/1ps

module packet_enqueue_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  pkt_bus_pkg::pkt_word_t    in_word,
    input  pkt_buf_pkg::buf_ptr_t     head_ptr,
    input  pkt_buf_pkg::buf_addr_t    rd_addr,
    output pkt_bus_pkg::pkt_data_t    rd_data,
    output logic                      desc_valid,
    output pkt_buf_pkg::pkt_desc_t    desc,
    output logic                      drop_valid,
    output pkt_buf_pkg::drop_reason_t drop_reason,
    output pkt_buf_pkg::buf_ptr_t     tail_ptr
);
    import pkt_bus_pkg::*;
    import pkt_buf_pkg::*;

    // Enqueue to buffer write port
    logic      wr_en;
    buf_addr_t wr_addr;
    pkt_data_t wr_data;

    packet_enqueue u_enqueue (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .head_ptr    (head_ptr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .desc_valid  (desc_valid),
        .desc        (desc),
        .drop_valid  (drop_valid),
        .drop_reason (drop_reason),
        .tail_ptr    (tail_ptr)
    );

    packet_buffer_mem u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- rtl/packet_buffer_mem.sv
`timescale 1ns/1ps
`include "pkt_macros.svh"

module packet_buffer_mem (
    input  logic                   clk,
    input  logic                   wr_en,
    input  pkt_buf_pkg::buf_addr_t wr_addr,
    input  pkt_bus_pkg::pkt_data_t wr_data,
    input  pkt_buf_pkg::buf_addr_t rd_addr,
    output pkt_bus_pkg::pkt_data_t rd_data
);
    import pkt_bus_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================

    pkt_data_t mem [`PKT_BUF_WORDS];

    // Write port, one word per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/packet_enqueue.sv
`timescale 1ns/1ps
`include "pkt_macros.svh"

module packet_enqueue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  pkt_bus_pkg::pkt_word_t    in_word,
    input  pkt_buf_pkg::buf_ptr_t     head_ptr,
    output logic                      wr_en,
    output pkt_buf_pkg::buf_addr_t    wr_addr,
    output pkt_bus_pkg::pkt_data_t    wr_data,
    output logic                      desc_valid,
    output pkt_buf_pkg::pkt_desc_t    desc,
    output logic                      drop_valid,
    output pkt_buf_pkg::drop_reason_t drop_reason,
    output pkt_buf_pkg::buf_ptr_t     tail_ptr
);
    import pkt_buf_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RECV,
        ST_DISCARD
    } state_t;

    state_t   state;

    // Running write pointer and space snapshot for the packet in flight
    buf_ptr_t wr_ptr;
    buf_ptr_t free_words;

    // Byte count holds once the packet is too long
    pkt_len_t byte_cnt;
    logic     long_seen;
    logic     ovfl_seen;

    // Per-word evaluation
    buf_ptr_t     free_now;
    buf_ptr_t     cur_ptr;
    buf_ptr_t     cur_free;
    pkt_len_t     cur_bytes;
    pkt_len_t     cur_len;
    logic         cur_long;
    logic         cur_short;
    logic         cur_ovfl;
    logic         keep;
    drop_reason_t reason;

    // ======================================================================
    // Word checks
    // ======================================================================

    assign free_now = buf_ptr_t'(`PKT_BUF_WORDS) - (tail_ptr - head_ptr);

    always_comb begin
        // First word of a packet lands at the committed tail
        cur_ptr  = (state == ST_IDLE) ? tail_ptr : wr_ptr;
        cur_free = (state == ST_IDLE) ? free_now : free_words;

        if (in_word.eop && (in_word.mty != '0)) begin
            cur_bytes = pkt_len_t'(in_word.mty);
        end else begin
            cur_bytes = pkt_len_t'(`PKT_WORD_BYTES);
        end
        cur_len = byte_cnt + cur_bytes;

        cur_long  = long_seen || (cur_len > pkt_len_t'(`PKT_MAX_BYTES));
        cur_short = cur_len < pkt_len_t'(`PKT_MIN_BYTES);

        // Word offset reaching the free count means the packet cannot fit
        cur_ovfl = ovfl_seen ||
                   ((state != ST_DISCARD) && ((cur_ptr - tail_ptr) >= cur_free));

        keep = !in_word.err && !cur_long && !cur_short && !cur_ovfl;

        if (in_word.err) begin
            reason = DROP_ERR;
        end else if (cur_long) begin
            reason = DROP_LONG;
        end else if (cur_short) begin
            reason = DROP_SHORT;
        end else begin
            reason = DROP_OVFL;
        end
    end

    // Each word is written on the edge that takes it
    assign wr_en   = in_valid && !cur_long && !cur_ovfl;
    assign wr_addr = buf_addr_t'(cur_ptr);
    assign wr_data = in_word.data;

    // ======================================================================
    // Packet state and tail pointer
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            tail_ptr   <= '0;
            byte_cnt   <= '0;
            long_seen  <= 1'b0;
            ovfl_seen  <= 1'b0;
            desc_valid <= 1'b0;
            drop_valid <= 1'b0;
        end else begin
            desc_valid <= 1'b0;
            drop_valid <= 1'b0;
            if (in_valid) begin
                if (in_word.eop) begin
                    state     <= ST_IDLE;
                    byte_cnt  <= '0;
                    long_seen <= 1'b0;
                    ovfl_seen <= 1'b0;
                    if (keep) begin
                        // Commit moves the tail past the last word written
                        desc_valid <= 1'b1;
                        tail_ptr   <= cur_ptr + buf_ptr_t'(1);
                    end else begin
                        drop_valid <= 1'b1;
                    end
                end else begin
                    if (cur_long || cur_ovfl) begin
                        state <= ST_DISCARD;
                    end else begin
                        state <= ST_RECV;
                    end
                    if (!cur_long) begin
                        byte_cnt <= cur_len;
                    end
                    long_seen <= cur_long;
                    ovfl_seen <= cur_ovfl;
                end
            end
        end
    end

    // Payload registers only matter while a packet is in flight or on a pulse
    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_ptr <= cur_ptr + buf_ptr_t'(1);
        end
        if (in_valid && (state == ST_IDLE)) begin
            free_words <= free_now;
        end
        if (in_valid && in_word.eop) begin
            desc.addr   <= buf_addr_t'(tail_ptr);
            desc.len    <= cur_len;
            desc.meta   <= in_word.meta;
            drop_reason <= reason;
        end
    end

endmodule

//--- rtl/pkt_buf_pkg.sv
`include "pkt_macros.svh"

package pkt_buf_pkg;

    // Word address into the buffer, plus a pointer form with an extra wrap bit
    typedef logic [$clog2(`PKT_BUF_WORDS)-1:0] buf_addr_t;
    typedef logic [$clog2(`PKT_BUF_WORDS):0]   buf_ptr_t;

    // Packet length in bytes
    typedef logic [10:0] pkt_len_t;

    typedef struct packed {
        buf_addr_t             addr;
        pkt_len_t              len;
        pkt_bus_pkg::pkt_meta_t meta;
    } pkt_desc_t;

    typedef enum logic [1:0] {
        DROP_ERR,
        DROP_SHORT,
        DROP_LONG,
        DROP_OVFL
    } drop_reason_t;

endpackage

//--- rtl/pkt_bus_pkg.sv
`include "pkt_macros.svh"

package pkt_bus_pkg;

    // One word of packet payload
    typedef logic [`PKT_WORD_BYTES*8-1:0] pkt_data_t;

    // Valid bytes in the last word, zero means the word is full
    typedef logic [$clog2(`PKT_WORD_BYTES)-1:0] pkt_mty_t;

    // Per-packet metadata, carried on the eop word
    typedef logic [15:0] pkt_meta_t;

    // One beat of the incoming stream
    // err and meta only count on the eop word
    typedef struct packed {
        pkt_data_t data;
        logic      eop;
        pkt_mty_t  mty;
        logic      err;
        pkt_meta_t meta;
    } pkt_word_t;

endpackage

//--- include/pkt_macros.svh
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// ==========================================================================
// Packet buffer sizing
// ==========================================================================

// Bytes carried by one stream word and stored in one buffer word
`define PKT_WORD_BYTES 4

// Buffer depth in words, a power of two so the pointers wrap cleanly
`define PKT_BUF_WORDS 64

// ==========================================================================
// Legal packet sizes in bytes
// ==========================================================================

`define PKT_MIN_BYTES 8
`define PKT_MAX_BYTES 64

`endif
